// ==== design/bpu_consts.svh ====
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

// address and fetch block geometry
`define ADDR_W              32
`define RESET_PC            32'h8000_0000
`define BLOCK_BYTES         16
`define INSN_BYTES          4

// ftb geometry, direct mapped
`define FTB_ENTRIES         64
`define FTB_IDX_W           6
`define FTB_IDX_LSB         4
`define FTB_TAG_W           22
`define FTB_TAG_LSB         10

// entry field widths
`define BLK_LEN_W           3
`define BR_TYPE_W           2
`define CTR_W               2

// 2-bit saturating counter
`define CTR_MAX             3
`define CTR_TAKEN_MIN       2
`define CTR_MISS            1
`define CTR_INIT_TAKEN      2
`define CTR_INIT_NOT_TAKEN  1

`endif

// ==== design/bpu_pkg.sv ====
`include "bpu_consts.svh"

package bpu_pkg;

    // byte address
    typedef logic [`ADDR_W-1:0] addr_t;

    // ftb index, address bits 9..4
    typedef logic [`FTB_IDX_W-1:0] ftb_idx_t;

    // ftb tag, address bits 31..10
    typedef logic [`FTB_TAG_W-1:0] ftb_tag_t;

    // block length in 4-byte instructions, 1 to 4
    typedef logic [`BLK_LEN_W-1:0] blk_len_t;

    // branch kind, carried through only
    // 0 conditional, 1 direct jump, 2 call, 3 return
    typedef logic [`BR_TYPE_W-1:0] br_type_t;

    // saturating direction counter
    typedef logic [`CTR_W-1:0] ctr_t;

    // entry updater sequence
    typedef enum logic [1:0] {
        UPD_IDLE,
        UPD_READ,
        UPD_WRITE,
        UPD_DONE
    } upd_state_e;

endpackage

// ==== design/ftb_array.sv ====
`include "bpu_consts.svh"

module ftb_array import bpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    input  logic     i_en,
    input  logic     i_we,
    input  ftb_idx_t i_idx,

    input  logic     i_wvalid,
    input  ftb_tag_t i_wtag,
    input  blk_len_t i_wlen,
    input  addr_t    i_wtarget,
    input  br_type_t i_wtype,
    input  ctr_t     i_wctr,

    output logic     o_rvalid,
    output ftb_tag_t o_rtag,
    output blk_len_t o_rlen,
    output addr_t    o_rtarget,
    output br_type_t o_rtype,
    output ctr_t     o_rctr
);

    logic [`FTB_ENTRIES-1:0] valid_q;
    ftb_tag_t                tag_mem    [`FTB_ENTRIES];
    blk_len_t                len_mem    [`FTB_ENTRIES];
    addr_t                   target_mem [`FTB_ENTRIES];
    br_type_t                type_mem   [`FTB_ENTRIES];
    ctr_t                    ctr_mem    [`FTB_ENTRIES];

    logic wr;
    logic rd;

    assign wr = i_en && i_we;
    assign rd = i_en && !i_we;

    // valid bits are flops so the table comes up empty
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr) begin
            valid_q[i_idx] <= i_wvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            tag_mem[i_idx]    <= i_wtag;
            len_mem[i_idx]    <= i_wlen;
            target_mem[i_idx] <= i_wtarget;
            type_mem[i_idx]   <= i_wtype;
            ctr_mem[i_idx]    <= i_wctr;
        end
    end

    // read data registered, holds across writes and idle cycles
    always_ff @(posedge clk) begin
        if (rd) begin
            o_rvalid  <= valid_q[i_idx];
            o_rtag    <= tag_mem[i_idx];
            o_rlen    <= len_mem[i_idx];
            o_rtarget <= target_mem[i_idx];
            o_rtype   <= type_mem[i_idx];
            o_rctr    <= ctr_mem[i_idx];
        end
    end

endmodule

// ==== design/ftb_arbiter.sv ====
module ftb_arbiter import bpu_pkg::*; (
    // updater side
    input  logic     i_upd_req,
    input  logic     i_upd_we,
    input  ftb_idx_t i_upd_idx,
    input  logic     i_upd_wvalid,
    input  ftb_tag_t i_upd_wtag,
    input  blk_len_t i_upd_wlen,
    input  addr_t    i_upd_wtarget,
    input  br_type_t i_upd_wtype,
    input  ctr_t     i_upd_wctr,
    output logic     o_upd_gnt,

    // prediction lookup side
    input  logic     i_lkp_req,
    input  ftb_idx_t i_lkp_idx,
    output logic     o_lkp_gnt,

    // array port
    output logic     o_en,
    output logic     o_we,
    output ftb_idx_t o_idx,
    output logic     o_wvalid,
    output ftb_tag_t o_wtag,
    output blk_len_t o_wlen,
    output addr_t    o_wtarget,
    output br_type_t o_wtype,
    output ctr_t     o_wctr
);

    // updater always wins, lookup takes the leftover cycles
    assign o_upd_gnt = i_upd_req;
    assign o_lkp_gnt = i_lkp_req && !i_upd_req;

    assign o_en  = i_upd_req || i_lkp_req;
    assign o_we  = i_upd_req && i_upd_we;
    assign o_idx = i_upd_req ? i_upd_idx : i_lkp_idx;

    // only the updater ever writes
    assign o_wvalid  = i_upd_wvalid;
    assign o_wtag    = i_upd_wtag;
    assign o_wlen    = i_upd_wlen;
    assign o_wtarget = i_upd_wtarget;
    assign o_wtype   = i_upd_wtype;
    assign o_wctr    = i_upd_wctr;

endmodule

// ==== design/ftb_updater.sv ====
`include "bpu_consts.svh"

module ftb_updater import bpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    input  logic     i_update_vld,
    input  addr_t    i_update_pc,
    input  logic     i_update_taken,
    input  addr_t    i_update_target,
    input  blk_len_t i_update_len,
    input  br_type_t i_update_type,

    input  logic     i_gnt,
    input  logic     i_rvalid,
    input  ftb_tag_t i_rtag,
    input  ctr_t     i_rctr,

    output logic     o_req,
    output logic     o_we,
    output ftb_idx_t o_idx,
    output logic     o_wvalid,
    output ftb_tag_t o_wtag,
    output blk_len_t o_wlen,
    output addr_t    o_wtarget,
    output br_type_t o_wtype,
    output ctr_t     o_wctr,

    output logic     o_busy,
    output logic     o_update_done
);

    upd_state_e state;
    upd_state_e state_nxt;

    addr_t    upd_pc;
    logic     upd_taken;
    addr_t    upd_target;
    blk_len_t upd_len;
    br_type_t upd_type;

    ftb_tag_t upd_tag;
    logic     entry_hit;
    ctr_t     trained_ctr;

    always_comb begin
        state_nxt = state;
        unique case (state)
            UPD_IDLE:  if (i_update_vld) state_nxt = UPD_READ;
            UPD_READ:  if (i_gnt) state_nxt = UPD_WRITE;
            UPD_WRITE: if (i_gnt) state_nxt = UPD_DONE;
            UPD_DONE:  state_nxt = UPD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= UPD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // capture the resolved branch, later pulses are ignored until idle
    always_ff @(posedge clk) begin
        if (state == UPD_IDLE && i_update_vld) begin
            upd_pc     <= i_update_pc;
            upd_taken  <= i_update_taken;
            upd_target <= i_update_target;
            upd_len    <= i_update_len;
            upd_type   <= i_update_type;
        end
    end

    assign upd_tag   = upd_pc[`ADDR_W-1:`FTB_TAG_LSB];
    assign entry_hit = i_rvalid && (i_rtag == upd_tag);

    // read data is stable during UPD_WRITE since that cycle only writes
    always_comb begin
        if (!entry_hit) begin
            trained_ctr = upd_taken ? ctr_t'(`CTR_INIT_TAKEN) : ctr_t'(`CTR_INIT_NOT_TAKEN);
        end else if (upd_taken) begin
            trained_ctr = (i_rctr == ctr_t'(`CTR_MAX)) ? i_rctr : i_rctr + ctr_t'(1);
        end else begin
            trained_ctr = (i_rctr == '0) ? i_rctr : i_rctr - ctr_t'(1);
        end
    end

    assign o_req = (state == UPD_READ) || (state == UPD_WRITE);
    assign o_we  = (state == UPD_WRITE);
    assign o_idx = upd_pc[`FTB_IDX_LSB+`FTB_IDX_W-1:`FTB_IDX_LSB];

    assign o_wvalid  = 1'b1;
    assign o_wtag    = upd_tag;
    assign o_wlen    = upd_len;
    assign o_wtarget = upd_target;
    assign o_wtype   = upd_type;
    assign o_wctr    = trained_ctr;

    assign o_busy        = (state != UPD_IDLE);
    assign o_update_done = (state == UPD_DONE);

endmodule

// ==== design/bpu_pipeline.sv ====
`include "bpu_consts.svh"

module bpu_pipeline import bpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    input  logic     i_squash_vld,
    input  addr_t    i_squash_pc,

    // ftb lookup port through the arbiter
    output logic     o_req,
    output ftb_idx_t o_idx,
    input  logic     i_gnt,
    input  logic     i_rvalid,
    input  ftb_tag_t i_rtag,
    input  blk_len_t i_rlen,
    input  addr_t    i_rtarget,
    input  br_type_t i_rtype,
    input  ctr_t     i_rctr,

    // block description to the fetch target queue
    input  logic     i_ftq_rdy,
    output logic     o_pred_vld,
    output addr_t    o_pred_start,
    output addr_t    o_pred_end,
    output addr_t    o_pred_target,
    output logic     o_pred_taken,
    output logic     o_pred_hit,
    output br_type_t o_pred_type,
    output ctr_t     o_pred_ctr
);

    // s0 fetch address
    addr_t    s0_pc;

    // s1 lookup result
    logic     s1_vld;
    logic     s1_fresh;
    addr_t    s1_pc;
    logic     s1_hold_valid;
    ftb_tag_t s1_hold_tag;
    blk_len_t s1_hold_len;
    addr_t    s1_hold_target;
    br_type_t s1_hold_type;
    ctr_t     s1_hold_ctr;

    // s1 entry view and formed block
    logic     e_valid;
    ftb_tag_t e_tag;
    blk_len_t e_len;
    addr_t    e_target;
    br_type_t e_type;
    ctr_t     e_ctr;

    logic     blk_hit;
    logic     blk_taken;
    addr_t    blk_end;
    addr_t    blk_next;
    addr_t    blk_seq;

    logic     out_free;
    logic     s1_move;
    logic     s1_free;
    logic     redirect;
    logic     s1_load;

    assign out_free = !o_pred_vld || i_ftq_rdy;
    assign s1_move  = s1_vld && out_free;
    assign s1_free  = !s1_vld || s1_move;

    assign o_req = s1_free;
    assign o_idx = s0_pc[`FTB_IDX_LSB+`FTB_IDX_W-1:`FTB_IDX_LSB];

    // array data is ours only in the first s1 cycle, later the held copy
    assign e_valid  = s1_fresh ? i_rvalid  : s1_hold_valid;
    assign e_tag    = s1_fresh ? i_rtag    : s1_hold_tag;
    assign e_len    = s1_fresh ? i_rlen    : s1_hold_len;
    assign e_target = s1_fresh ? i_rtarget : s1_hold_target;
    assign e_type   = s1_fresh ? i_rtype   : s1_hold_type;
    assign e_ctr    = s1_fresh ? i_rctr    : s1_hold_ctr;

    assign blk_hit   = e_valid && (e_tag == s1_pc[`ADDR_W-1:`FTB_TAG_LSB]);
    assign blk_taken = blk_hit && (e_ctr >= ctr_t'(`CTR_TAKEN_MIN));
    assign blk_seq   = s1_pc + addr_t'(`BLOCK_BYTES);
    assign blk_end   = blk_hit ? s1_pc + addr_t'(e_len) * addr_t'(`INSN_BYTES) : blk_seq;
    assign blk_next  = blk_taken ? e_target : blk_end;

    // a grant in the redirect cycle carries the wrong address
    assign redirect = s1_move && (blk_next != blk_seq);
    assign s1_load  = i_gnt && !redirect && !i_squash_vld;

    always_ff @(posedge clk) begin
        if (rst) begin
            s0_pc <= `RESET_PC;
        end else if (i_squash_vld) begin
            s0_pc <= i_squash_pc;
        end else if (redirect) begin
            s0_pc <= blk_next;
        end else if (i_gnt) begin
            s0_pc <= s0_pc + addr_t'(`BLOCK_BYTES);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld   <= 1'b0;
            s1_fresh <= 1'b0;
        end else begin
            s1_fresh <= s1_load;
            if (i_squash_vld) begin
                s1_vld <= 1'b0;
            end else if (s1_free) begin
                s1_vld <= s1_load;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_load) begin
            s1_pc <= s0_pc;
        end
        if (s1_fresh) begin
            s1_hold_valid  <= i_rvalid;
            s1_hold_tag    <= i_rtag;
            s1_hold_len    <= i_rlen;
            s1_hold_target <= i_rtarget;
            s1_hold_type   <= i_rtype;
            s1_hold_ctr    <= i_rctr;
        end
    end

    // output register, frozen while the queue is not ready
    always_ff @(posedge clk) begin
        if (rst) begin
            o_pred_vld <= 1'b0;
        end else if (i_squash_vld) begin
            o_pred_vld <= 1'b0;
        end else if (out_free) begin
            o_pred_vld <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_move) begin
            o_pred_start  <= s1_pc;
            o_pred_end    <= blk_end;
            o_pred_target <= blk_hit ? e_target : '0;
            o_pred_taken  <= blk_taken;
            o_pred_hit    <= blk_hit;
            o_pred_type   <= blk_hit ? e_type : '0;
            o_pred_ctr    <= blk_hit ? e_ctr : ctr_t'(`CTR_MISS);
        end
    end

endmodule

// ==== design/bpu_top.sv ====
module bpu_top import bpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    input  logic     i_squash_vld,
    input  addr_t    i_squash_pc,

    input  logic     i_update_vld,
    input  addr_t    i_update_pc,
    input  logic     i_update_taken,
    input  addr_t    i_update_target,
    input  blk_len_t i_update_len,
    input  br_type_t i_update_type,
    output logic     o_update_done,

    input  logic     i_ftq_rdy,
    output logic     o_pred_vld,
    output addr_t    o_pred_start,
    output addr_t    o_pred_end,
    output addr_t    o_pred_target,
    output logic     o_pred_taken,
    output logic     o_pred_hit,
    output br_type_t o_pred_type,
    output ctr_t     o_pred_ctr
);

    // updater request side
    logic     upd_req;
    logic     upd_we;
    ftb_idx_t upd_idx;
    logic     upd_wvalid;
    ftb_tag_t upd_wtag;
    blk_len_t upd_wlen;
    addr_t    upd_wtarget;
    br_type_t upd_wtype;
    ctr_t     upd_wctr;
    logic     upd_gnt;

    // lookup request side
    logic     lkp_req;
    ftb_idx_t lkp_idx;
    logic     lkp_gnt;

    // shared array port
    logic     arr_en;
    logic     arr_we;
    ftb_idx_t arr_idx;
    logic     arr_wvalid;
    ftb_tag_t arr_wtag;
    blk_len_t arr_wlen;
    addr_t    arr_wtarget;
    br_type_t arr_wtype;
    ctr_t     arr_wctr;
    logic     arr_rvalid;
    ftb_tag_t arr_rtag;
    blk_len_t arr_rlen;
    addr_t    arr_rtarget;
    br_type_t arr_rtype;
    ctr_t     arr_rctr;

    bpu_pipeline bpu_pipeline_i (
        .clk           (clk),
        .rst           (rst),
        .i_squash_vld  (i_squash_vld),
        .i_squash_pc   (i_squash_pc),
        .o_req         (lkp_req),
        .o_idx         (lkp_idx),
        .i_gnt         (lkp_gnt),
        .i_rvalid      (arr_rvalid),
        .i_rtag        (arr_rtag),
        .i_rlen        (arr_rlen),
        .i_rtarget     (arr_rtarget),
        .i_rtype       (arr_rtype),
        .i_rctr        (arr_rctr),
        .i_ftq_rdy     (i_ftq_rdy),
        .o_pred_vld    (o_pred_vld),
        .o_pred_start  (o_pred_start),
        .o_pred_end    (o_pred_end),
        .o_pred_target (o_pred_target),
        .o_pred_taken  (o_pred_taken),
        .o_pred_hit    (o_pred_hit),
        .o_pred_type   (o_pred_type),
        .o_pred_ctr    (o_pred_ctr)
    );

    ftb_updater ftb_updater_i (
        .clk             (clk),
        .rst             (rst),
        .i_update_vld    (i_update_vld),
        .i_update_pc     (i_update_pc),
        .i_update_taken  (i_update_taken),
        .i_update_target (i_update_target),
        .i_update_len    (i_update_len),
        .i_update_type   (i_update_type),
        .i_gnt           (upd_gnt),
        .i_rvalid        (arr_rvalid),
        .i_rtag          (arr_rtag),
        .i_rctr          (arr_rctr),
        .o_req           (upd_req),
        .o_we            (upd_we),
        .o_idx           (upd_idx),
        .o_wvalid        (upd_wvalid),
        .o_wtag          (upd_wtag),
        .o_wlen          (upd_wlen),
        .o_wtarget       (upd_wtarget),
        .o_wtype         (upd_wtype),
        .o_wctr          (upd_wctr),
        .o_busy          (),
        .o_update_done   (o_update_done)
    );

    ftb_arbiter ftb_arbiter_i (
        .i_upd_req     (upd_req),
        .i_upd_we      (upd_we),
        .i_upd_idx     (upd_idx),
        .i_upd_wvalid  (upd_wvalid),
        .i_upd_wtag    (upd_wtag),
        .i_upd_wlen    (upd_wlen),
        .i_upd_wtarget (upd_wtarget),
        .i_upd_wtype   (upd_wtype),
        .i_upd_wctr    (upd_wctr),
        .o_upd_gnt     (upd_gnt),
        .i_lkp_req     (lkp_req),
        .i_lkp_idx     (lkp_idx),
        .o_lkp_gnt     (lkp_gnt),
        .o_en          (arr_en),
        .o_we          (arr_we),
        .o_idx         (arr_idx),
        .o_wvalid      (arr_wvalid),
        .o_wtag        (arr_wtag),
        .o_wlen        (arr_wlen),
        .o_wtarget     (arr_wtarget),
        .o_wtype       (arr_wtype),
        .o_wctr        (arr_wctr)
    );

    ftb_array ftb_array_i (
        .clk       (clk),
        .rst       (rst),
        .i_en      (arr_en),
        .i_we      (arr_we),
        .i_idx     (arr_idx),
        .i_wvalid  (arr_wvalid),
        .i_wtag    (arr_wtag),
        .i_wlen    (arr_wlen),
        .i_wtarget (arr_wtarget),
        .i_wtype   (arr_wtype),
        .i_wctr    (arr_wctr),
        .o_rvalid  (arr_rvalid),
        .o_rtag    (arr_rtag),
        .o_rlen    (arr_rlen),
        .o_rtarget (arr_rtarget),
        .o_rtype   (arr_rtype),
        .o_rctr    (arr_rctr)
    );

endmodule

// ==== test/bpu_ref_model.svh ====
`ifndef BPU_REF_MODEL_SVH
`define BPU_REF_MODEL_SVH

// reference ftb table, one direct mapped entry per index
logic     m_valid  [`FTB_ENTRIES];
ftb_tag_t m_tag    [`FTB_ENTRIES];
blk_len_t m_len    [`FTB_ENTRIES];
addr_t    m_target [`FTB_ENTRIES];
br_type_t m_type   [`FTB_ENTRIES];
ctr_t     m_ctr    [`FTB_ENTRIES];

// training events worth seeing at least once
int sat_seen = 0;
int realloc_seen = 0;

logic [31:0] rand_state = 32'heb28_87c1;

function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
endfunction

// low lcg bits repeat quickly, use the upper ones
function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'({8'd0, r[31:8]}) % n;
endfunction

function automatic ftb_idx_t model_idx(input addr_t pc);
    return pc[`FTB_IDX_LSB+`FTB_IDX_W-1:`FTB_IDX_LSB];
endfunction

function automatic ftb_tag_t model_tag(input addr_t pc);
    return pc[`ADDR_W-1:`FTB_TAG_LSB];
endfunction

function automatic void model_reset();
    int i;
    for (i = 0; i < `FTB_ENTRIES; i++) begin
        m_valid[i] = 1'b0;
    end
endfunction

// counter trains on a tag match, anything else allocates fresh
function automatic void model_update(input addr_t pc, input logic taken, input addr_t target,
                                     input blk_len_t len, input br_type_t typ);
    ftb_idx_t idx;
    idx = model_idx(pc);
    if (m_valid[idx] && m_tag[idx] == model_tag(pc)) begin
        if (taken) begin
            if (m_ctr[idx] == 2'd3) sat_seen++;
            else m_ctr[idx] = m_ctr[idx] + 2'd1;
        end else begin
            if (m_ctr[idx] == 2'd0) sat_seen++;
            else m_ctr[idx] = m_ctr[idx] - 2'd1;
        end
    end else begin
        if (m_valid[idx]) realloc_seen++;
        m_ctr[idx] = taken ? ctr_t'(`CTR_INIT_TAKEN) : ctr_t'(`CTR_INIT_NOT_TAKEN);
    end
    m_valid[idx]  = 1'b1;
    m_tag[idx]    = model_tag(pc);
    m_len[idx]    = len;
    m_target[idx] = target;
    m_type[idx]   = typ;
endfunction

task automatic predict_block(input addr_t start, output addr_t blk_end, output addr_t target,
                             output logic taken, output logic hit, output br_type_t typ,
                             output ctr_t ctr);
    ftb_idx_t idx;
    idx = model_idx(start);
    hit = m_valid[idx] && (m_tag[idx] == model_tag(start));
    if (hit) begin
        blk_end = start + addr_t'(m_len[idx]) * 32'd4;
        // taken for the upper half of the counter range
        taken   = (m_ctr[idx] >= 2'd2);
        target  = m_target[idx];
        typ     = m_type[idx];
        ctr     = m_ctr[idx];
    end else begin
        blk_end = start + 32'd16;
        taken   = 1'b0;
        target  = '0;
        typ     = '0;
        ctr     = 2'd1;
    end
endtask

`endif

// ==== test/bpu_tb.sv ====
`include "bpu_consts.svh"

module bpu_tb import bpu_pkg::*; ();

    logic     clk;
    logic     rst;
    logic     i_squash_vld;
    addr_t    i_squash_pc;
    logic     i_update_vld;
    addr_t    i_update_pc;
    logic     i_update_taken;
    addr_t    i_update_target;
    blk_len_t i_update_len;
    br_type_t i_update_type;
    logic     o_update_done;
    logic     i_ftq_rdy;
    logic     o_pred_vld;
    addr_t    o_pred_start;
    addr_t    o_pred_end;
    addr_t    o_pred_target;
    logic     o_pred_taken;
    logic     o_pred_hit;
    br_type_t o_pred_type;
    ctr_t     o_pred_ctr;

    `include "bpu_ref_model.svh"

    // scoreboard state
    addr_t    exp_start = `RESET_PC;
    logic     in_update = 1'b0;
    int       done_wait = -1;
    int       accepted = 0;

    // output copy while the queue stalls
    logic     held = 1'b0;
    addr_t    held_start;
    addr_t    held_end;
    addr_t    held_target;
    logic     held_taken;
    logic     held_hit;
    br_type_t held_type;
    ctr_t     held_ctr;

    // expected block from the model
    addr_t    e_end;
    addr_t    e_target;
    logic     e_taken;
    logic     e_hit;
    br_type_t e_type;
    ctr_t     e_ctr;

    bpu_top bpu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic expect_true(input logic ok, input string what);
        assert (ok) else begin
            $display("CHECK FAILED at time %0t: %s", $time, what);
            $display("Test FAILED");
            $fatal(1, "stopped at first failing check");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "run aborted");
    endtask

    // one clock with a fresh ready level
    task automatic tick();
        @(posedge clk);
        i_ftq_rdy <= (rand_below(4) != 0);
    endtask

    // a quarter of the draws land in an alias window with the same indices
    function automatic addr_t window_addr(input int blocks);
        addr_t base;
        base = (rand_below(4) == 0) ? addr_t'(`RESET_PC + 32'h400) : addr_t'(`RESET_PC);
        return base + addr_t'(rand_below(blocks) * `BLOCK_BYTES);
    endfunction

    task automatic wait_for_blocks(input int count);
        int goal;
        int waited;
        goal = accepted + count;
        waited = 0;
        while (accepted < goal) begin
            tick();
            waited++;
            if (waited > 40 * count) begin
                abort_run($sformatf("timeout: %0d blocks were not accepted in time", count));
            end
        end
    endtask

    task automatic run_update();
        addr_t    pc;
        addr_t    target;
        logic     taken;
        blk_len_t len;
        br_type_t typ;
        int       waited;
        // few branch addresses so counters get trained repeatedly
        pc     = window_addr(8);
        target = window_addr(16);
        taken  = (rand_below(4) != 0);
        len    = blk_len_t'(1 + rand_below(4));
        typ    = br_type_t'(rand_below(4));
        i_update_vld    <= 1'b1;
        i_update_pc     <= pc;
        i_update_taken  <= taken;
        i_update_target <= target;
        i_update_len    <= len;
        i_update_type   <= typ;
        tick();
        i_update_vld <= 1'b0;
        waited = 0;
        while (!o_update_done) begin
            tick();
            waited++;
            if (waited > 10) begin
                abort_run("timeout: the updater never signalled completion");
            end
        end
        model_update(pc, taken, target, len, typ);
        i_squash_vld <= 1'b1;
        i_squash_pc  <= window_addr(16);
        tick();
        i_squash_vld <= 1'b0;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (held) begin
                expect_true(o_pred_vld && o_pred_start == held_start && o_pred_end == held_end
                            && o_pred_target == held_target && o_pred_taken == held_taken
                            && o_pred_hit == held_hit && o_pred_type == held_type
                            && o_pred_ctr == held_ctr,
                            "prediction outputs changed while the queue was not ready");
            end
            if (o_pred_vld && i_ftq_rdy) begin
                expect_true(o_pred_start == exp_start,
                            $sformatf("block start %h, expected %h", o_pred_start, exp_start));
                // blocks looked up around an update are only followed for continuity
                if (!in_update) begin
                    predict_block(o_pred_start, e_end, e_target, e_taken, e_hit, e_type, e_ctr);
                    expect_true(o_pred_end == e_end && o_pred_taken == e_taken
                                && o_pred_target == e_target && o_pred_hit == e_hit
                                && o_pred_type == e_type && o_pred_ctr == e_ctr,
                                {$sformatf("block %h end %h tk %b tgt %h hit %b ty %0d ctr %0d",
                                           o_pred_start, o_pred_end, o_pred_taken,
                                           o_pred_target, o_pred_hit, o_pred_type, o_pred_ctr),
                                 $sformatf(", expected %h %b %h %b %0d %0d",
                                           e_end, e_taken, e_target, e_hit, e_type, e_ctr)});
                end
                exp_start = o_pred_taken ? o_pred_target : o_pred_end;
                accepted <= accepted + 1;
            end
            held        = o_pred_vld && !i_ftq_rdy && !i_squash_vld;
            held_start  = o_pred_start;
            held_end    = o_pred_end;
            held_target = o_pred_target;
            held_taken  = o_pred_taken;
            held_hit    = o_pred_hit;
            held_type   = o_pred_type;
            held_ctr    = o_pred_ctr;
            if (i_squash_vld) begin
                exp_start = i_squash_pc;
                in_update = 1'b0;
            end
            if (done_wait >= 0) begin
                done_wait++;
            end
            if (o_update_done) begin
                expect_true(done_wait >= 0, "update done pulse without a pending update");
                expect_true(done_wait == 3,
                            $sformatf("update done %0d cycles after the pulse, expected 3",
                                      done_wait));
                done_wait = -1;
            end else begin
                expect_true(done_wait < 3, "update done missing three cycles after the pulse");
            end
            if (i_update_vld) begin
                in_update = 1'b1;
                done_wait = 0;
            end
        end
    end

    initial begin
        int round;
        rst             <= 1'b1;
        i_squash_vld    <= 1'b0;
        i_squash_pc     <= '0;
        i_update_vld    <= 1'b0;
        i_update_pc     <= '0;
        i_update_taken  <= 1'b0;
        i_update_target <= '0;
        i_update_len    <= '0;
        i_update_type   <= '0;
        i_ftq_rdy       <= 1'b0;
        model_reset();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // first phase runs on an empty table
        for (round = 0; round < 70; round++) begin
            wait_for_blocks(8 + rand_below(12));
            run_update();
        end
        wait_for_blocks(16);
        if (sat_seen > 0 && realloc_seen > 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("updates never saturated a counter or replaced a live entry");
            $display("Test FAILED");
            $fatal(1, "training not exercised");
        end
    end

endmodule

// ==== bpu.f ====
+incdir+design
+incdir+test
design/bpu_pkg.sv
design/ftb_array.sv
design/ftb_arbiter.sv
design/ftb_updater.sv
design/bpu_pipeline.sv
design/bpu_top.sv
test/bpu_tb.sv

// ==== Makefile ====
# verilator build and run of the bpu testbench
TOP := bpu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f bpu.f

# a failing run ends in $$fatal, so the exit status carries the result
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
